// ==== logic/pd_pkg.sv ====
// Shared definitions of the fetch and decode front end
//   machine word, opcode class and instruction field layout
//   decoded record passed to the downstream sink
//   R0 flag vector and its bit positions
//   IN/OU opcodes, conditional jump flag-select tables, reset PC

package pd_pkg;

	typedef logic [0:15] word_t;	// Bit 0 is the MSB

	// Opcode class, from IR bits 0..5 read as octal
	typedef enum logic [3:0] {
		ILL,		// 000-017
		NORM_A,		// 020-037 normal argument
		NORM_B,		// 040-057 normal argument
		KA1,		// 060-067 short argument
		JS,			// 070 short jumps
		KA2,		// 071 byte and short ops
		CGRP,		// 072 register shifts and misc
		SGRP,		// 073 system ops
		JGRP,		// 074 conditional jumps
		LGRP,		// 075
		GGRP,		// 076
		BNGRP		// 077 B/N group
	} op_class_t;

	typedef struct packed {
		logic [0:5] opcode;	// IR 0..5
		logic d;			// IR 6
		logic [0:2] a;		// IR 7..9
		logic [0:2] b;		// IR 10..12
		logic [0:2] c;		// IR 13..15
	} ir_fields_t;

	typedef struct packed {
		word_t pc;			// Address of the instruction word
		word_t ir;
		word_t arg;			// Valid only with two_word
		logic two_word;
		op_class_t cls;
		ir_fields_t f;
		logic xi;			// Illegal
		logic nef;			// Ineffective
	} pd_rec_t;

	typedef logic [0:8] r0_t;	// Z M V C L E G Y X

	localparam logic [3:0] R0_Z = 4'd0;
	localparam logic [3:0] R0_M = 4'd1;
	localparam logic [3:0] R0_V = 4'd2;
	localparam logic [3:0] R0_C = 4'd3;
	localparam logic [3:0] R0_L = 4'd4;
	localparam logic [3:0] R0_E = 4'd5;
	localparam logic [3:0] R0_G = 4'd6;
	localparam logic [3:0] R0_Y = 4'd7;
	localparam logic [3:0] R0_X = 4'd8;

	localparam logic [0:5] OP_IN = 6'o36;
	localparam logic [0:5] OP_OU = 6'o35;

	// Flag tested by a conditional jump
	typedef struct packed {
		logic chk;			// Jump is conditional
		logic inv;			// Test the inverted flag
		logic [3:0] idx;	// R0 bit position
	} flag_sel_t;

	localparam flag_sel_t SEL_NONE = '{1'b0, 1'b0, 4'd0};	// Always effective

	// JS group, indexed by A
	localparam flag_sel_t [0:7] JS_FLAG_SEL = '{
		SEL_NONE, SEL_NONE, SEL_NONE, SEL_NONE,	// JUS, JLS, ENS, RIS
		'{1'b1, 1'b0, R0_V},	// JVS
		'{1'b1, 1'b0, R0_X},	// JXS
		'{1'b1, 1'b0, R0_Y},	// JYS
		'{1'b1, 1'b0, R0_C}		// JCS
	};

	// J group, indexed by A
	localparam flag_sel_t [0:7] J_FLAG_SEL = '{
		SEL_NONE,				// UJ
		'{1'b1, 1'b0, R0_L},	// JL
		'{1'b1, 1'b0, R0_E},	// JE
		'{1'b1, 1'b0, R0_G},	// JG
		'{1'b1, 1'b0, R0_Z},	// JZ
		'{1'b1, 1'b0, R0_M},	// JM
		'{1'b1, 1'b1, R0_M},	// JN, not M
		SEL_NONE				// LJ
	};

	localparam word_t RESET_PC = 16'h0000;

endpackage

// ==== logic/ifetch.sv ====
// Instruction fetch sequencer
//   Wishbone classic read master, one word per bus cycle
//   program counter, instruction and argument registers
//   valid/ready offer of the held instruction

`timescale 1ns/1ns

module ifetch (
	input  logic clk,
	input  logic rst_n,
	output logic cyc,					// Wishbone master
	output logic stb,
	output logic we,
	output pd_pkg::word_t adr,
	input  pd_pkg::word_t dat_r,
	input  logic ack,
	input  pd_pkg::op_class_t cls,		// Class of the held IR
	output pd_pkg::word_t ir,
	output pd_pkg::word_t arg,
	output pd_pkg::word_t pc,			// Address of IR
	output logic two_word,
	output logic rec_valid,
	input  logic rec_ready
);

	import pd_pkg::*;

	typedef enum logic [1:0] {
		S_INSN,		// Read instruction word
		S_ARG,		// Decide, then read argument word
		S_OFFER		// Hold record until taken
	} fetch_state_t;

	fetch_state_t state;
	word_t fetch_pc;	// Next word to read
	logic ack_insn;
	logic ack_arg;

	assign stb = cyc;		// Single transfer per cycle
	assign we = 1'b0;		// Read only
	assign adr = fetch_pc;	// Moves only at ack, so stable during cycle

	assign ack_insn = cyc & ack & (state == S_INSN);
	assign ack_arg = cyc & ack & (state == S_ARG);

	// Normal argument in the next word when C=0
	assign two_word = ((cls == NORM_A) || (cls == NORM_B)) && (ir[13:15] == 3'b000);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_INSN;
			cyc <= 1'b0;
			rec_valid <= 1'b0;
			fetch_pc <= RESET_PC;
		end else begin
			case (state)
				S_INSN: begin
					if (!cyc) begin
						cyc <= 1'b1;	// First read after reset
					end else if (ack) begin
						cyc <= 1'b0;
						fetch_pc <= fetch_pc + 16'd1;
						state <= S_ARG;
					end
				end
				S_ARG: begin
					if (!cyc) begin
						// IR is held here, class is valid
						if (two_word) begin
							cyc <= 1'b1;
						end else begin
							rec_valid <= 1'b1;
							state <= S_OFFER;
						end
					end else if (ack) begin
						cyc <= 1'b0;
						fetch_pc <= fetch_pc + 16'd1;
						rec_valid <= 1'b1;
						state <= S_OFFER;
					end
				end
				S_OFFER: begin
					if (rec_ready) begin
						rec_valid <= 1'b0;
						cyc <= 1'b1;	// Next instruction right after transfer
						state <= S_INSN;
					end
				end
				default: begin
					state <= S_INSN;
					cyc <= 1'b0;
					rec_valid <= 1'b0;
				end
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (ack_insn) begin
			ir <= dat_r;
			pc <= fetch_pc;		// Address just read
		end
		if (ack_arg) begin
			arg <= dat_r;
		end
	end

endmodule

// ==== logic/op_decode.sv ====
// Opcode group and field decoder
//   three 16-way decoders over IR bits 2..5, one per range of IR 0..1
//   merge of the decoder outputs into one opcode class
//   slicing of the D, A, B and C fields

`timescale 1ns/1ns

module op_decode (
	input  pd_pkg::word_t ir,
	output pd_pkg::op_class_t cls,
	output pd_pkg::ir_fields_t f
);

	import pd_pkg::*;

	logic [0:15] dec01;		// 020-037
	logic [0:15] dec10;		// 040-057
	logic [0:15] dec11;		// 060-077

	// One-hot 4-to-16 decoder with enable
	function automatic logic [0:15] dec16(input logic en, input logic [0:3] sel);
		logic [0:15] o;
		o = '0;
		if (en) begin
			o[sel] = 1'b1;
		end
		return o;
	endfunction

	assign dec01 = dec16(ir[0:1] == 2'b01, ir[2:5]);	// LW .. PUFA
	assign dec10 = dec16(ir[0:1] == 2'b10, ir[2:5]);	// AW .. CB
	assign dec11 = dec16(ir[0:1] == 2'b11, ir[2:5]);	// AWT .. B/N

	// 000-017 enable none of the decoders
	always_comb begin
		cls = ILL;
		if (|dec01) begin
			cls = NORM_A;
		end else if (|dec10) begin
			cls = NORM_B;
		end else if (|dec11[0:7]) begin
			cls = KA1;		// AWT TRB IRB DRB CWT LWT LWS RWS
		end else begin
			case (1'b1)
				dec11[8]: cls = JS;
				dec11[9]: cls = KA2;
				dec11[10]: cls = CGRP;
				dec11[11]: cls = SGRP;
				dec11[12]: cls = JGRP;
				dec11[13]: cls = LGRP;
				dec11[14]: cls = GGRP;
				dec11[15]: cls = BNGRP;
				default: cls = ILL;
			endcase
		end
	end

	// Field slicing
	assign f.opcode = ir[0:5];
	assign f.d = ir[6];		// Indirect / sign bit
	assign f.a = ir[7:9];	// Register A
	assign f.b = ir[10:12];	// B-modifier
	assign f.c = ir[13:15];	// Register C, 0 for next-word argument

endmodule

// ==== logic/op_check.sv ====
// Illegal and ineffective instruction detection
//   illegal rules for empty opcodes, S, B/N, C groups and IN/OU in user mode
//   conditional jump test against the R0 flags for JS and J groups

`timescale 1ns/1ns

module op_check #(
	parameter bit inou_user_illegal = 1'b1	// IN/OU trap in user mode
) (
	input  pd_pkg::op_class_t cls,
	input  pd_pkg::ir_fields_t f,
	input  logic q,					// User mode
	input  pd_pkg::r0_t r0,
	output logic xi,
	output logic nef
);

	import pd_pkg::*;

	logic a_hi;			// A is 5, 6 or 7
	logic s_ill;
	logic bn_ill;
	logic c_ill;
	logic io_ill;
	flag_sel_t sel;
	logic jump_nef;

	assign a_hi = (f.a >= 3'd5);

	// Unused S codes, and the whole group for user
	assign s_ill = (cls == SGRP) & (a_hi | q);
	// Upper B/N codes are privileged
	assign bn_ill = (cls == BNGRP) & a_hi & q;
	// Unassigned C group codes
	assign c_ill = (cls == CGRP) & (f.b[0] | (f.b[1] & f.b[2]));
	assign io_ill = ((f.opcode == OP_IN) | (f.opcode == OP_OU)) & q & inou_user_illegal;

	assign xi = (cls == ILL) | s_ill | bn_ill | c_ill | io_ill;

	// Flag select for conditional jumps
	always_comb begin
		sel = SEL_NONE;
		if (cls == JS) begin
			sel = JS_FLAG_SEL[f.a];
		end else if (cls == JGRP) begin
			sel = J_FLAG_SEL[f.a];
		end
	end

	assign jump_nef = sel.chk & ~(r0[sel.idx] ^ sel.inv);	// Condition not met

	assign nef = xi | jump_nef;

endmodule

// ==== logic/pd_top.sv ====
// Fetch and decode front end
//   instruction fetch over Wishbone
//   opcode class and field decode
//   illegal and ineffective check
//   packing of the downstream record

`timescale 1ns/1ns

module pd_top #(
	parameter bit inou_user_illegal = 1'b1
) (
	input  logic clk,
	input  logic rst_n,
	output logic cyc,
	output logic stb,
	output logic we,
	output pd_pkg::word_t adr,
	input  pd_pkg::word_t dat_r,
	input  logic ack,
	input  logic q,
	input  pd_pkg::r0_t r0,
	output pd_pkg::pd_rec_t rec,
	output logic rec_valid,
	input  logic rec_ready
);

	import pd_pkg::*;

	word_t ir;
	word_t arg;
	word_t pc;
	logic two_word;
	op_class_t cls;
	ir_fields_t f;
	logic xi;
	logic nef;

	ifetch u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_r(dat_r),
		.ack(ack),
		.cls(cls),			// Needed for the argument decision
		.ir(ir),
		.arg(arg),
		.pc(pc),
		.two_word(two_word),
		.rec_valid(rec_valid),
		.rec_ready(rec_ready)
	);

	op_decode u_decode (
		.ir(ir),
		.cls(cls),
		.f(f)
	);

	op_check #(
		.inou_user_illegal(inou_user_illegal)
	) u_check (
		.cls(cls),
		.f(f),
		.q(q),
		.r0(r0),
		.xi(xi),
		.nef(nef)
	);

	assign rec = '{pc: pc, ir: ir, arg: arg, two_word: two_word,
		cls: cls, f: f, xi: xi, nef: nef};

endmodule

// ==== bench/pd_check.sv ====
// Checker for the fetch and decode front end
//   model of class, field, illegal and flag-select rules
//   walk of the program memory with its own pc
//   bus, reset and back-pressure checks
//   per-test result lines and the closing count line

`timescale 1ns/1ns

module pd_check #(
	parameter bit inou_user_illegal = 1'b1,
	parameter int n_records = 120
) (
	input  logic clk,
	input  logic rst_n,
	input  logic cyc,
	input  logic stb,
	input  logic we,
	input  pd_pkg::word_t adr,
	input  logic ack,
	input  logic q,
	input  pd_pkg::r0_t r0,
	input  pd_pkg::pd_rec_t rec,
	input  logic rec_valid,
	input  logic rec_ready,
	output logic done,
	output int errors
);

	import pd_pkg::*;

	int test_err [1:6];
	int n_rec, n_two, stalls;
	word_t model_pc;
	word_t bus_adr;		// Address at request start
	logic bus_busy;
	logic in_reset, first_seen, held;
	pd_rec_t held_rec;	// Record offered but not taken
	logic [0:11] seen;	// Classes met so far

	function automatic op_class_t class_of(logic [0:5] op);
		if (op < 6'o20) return ILL;
		if (op < 6'o40) return NORM_A;
		if (op < 6'o60) return NORM_B;
		if (op < 6'o70) return KA1;
		case (op)
			6'o70: return JS;
			6'o71: return KA2;
			6'o72: return CGRP;
			6'o73: return SGRP;
			6'o74: return JGRP;
			6'o75: return LGRP;
			6'o76: return GGRP;
			default: return BNGRP;
		endcase
	endfunction

	function automatic logic illegal(op_class_t c, logic [0:5] op, logic [0:2] a,
		logic [0:2] b, logic user);
		logic bad;
		case (c)
			ILL: bad = 1'b1;
			SGRP: bad = user || a >= 3'd5;
			BNGRP: bad = user && a >= 3'd5;
			CGRP: bad = b[0] || (b[1] && b[2]);
			default: bad = 1'b0;
		endcase
		if ((op == 6'o35 || op == 6'o36) && user && inou_user_illegal) bad = 1'b1;
		return bad;
	endfunction

	// Conditional jump whose tested flag is clear
	function automatic logic jump_fails(op_class_t c, logic [0:2] a, r0_t fl);
		logic flag;
		flag = 1'b1;	// Unconditional forms
		if (c == JS) begin
			case (a)
				3'd4: flag = fl[2];		// V
				3'd5: flag = fl[8];		// X
				3'd6: flag = fl[7];		// Y
				3'd7: flag = fl[3];		// C
				default: flag = 1'b1;
			endcase
		end else if (c == JGRP) begin
			case (a)
				3'd1: flag = fl[4];		// L
				3'd2: flag = fl[5];		// E
				3'd3: flag = fl[6];		// G
				3'd4: flag = fl[0];		// Z
				3'd5: flag = fl[1];		// M
				3'd6: flag = !fl[1];	// N
				default: flag = 1'b1;
			endcase
		end
		return !flag;
	endfunction

	function automatic string test_title(int t);
		case (t)
			1: return "reset and bus";
			2: return "pc, ir, class and fields";
			3: return "two-word instructions";
			4: return "illegal flag xi";
			5: return "ineffective flag nef";
			default: return "back-pressure";
		endcase
	endfunction

	task automatic bad_value(int t, string name, logic [79:0] exp, logic [79:0] got);
		$display("ERROR %s expected %h got %h at %0t", name, exp, got, $time);
		test_err[t]++;
	endtask

	task automatic failure(int t, string what);
		$display("Check failed: %s at %0t", what, $time);
		test_err[t]++;
	endtask

	task automatic check_record();
		pd_rec_t e;
		e.pc = model_pc;
		e.ir = pd_tb.mem[model_pc[8:15]];
		e.cls = class_of(e.ir[0:5]);
		e.f.opcode = e.ir[0:5];
		e.f.d = e.ir[6];
		e.f.a = e.ir[7:9];
		e.f.b = e.ir[10:12];
		e.f.c = e.ir[13:15];
		e.two_word = (e.cls == NORM_A || e.cls == NORM_B) && e.f.c == 3'd0;
		e.arg = pd_tb.mem[8'(model_pc[8:15] + 8'd1)];
		e.xi = illegal(e.cls, e.f.opcode, e.f.a, e.f.b, q);
		e.nef = e.xi || jump_fails(e.cls, e.f.a, r0);
		if (rec.pc !== e.pc) bad_value(2, "rec.pc", e.pc, rec.pc);
		if (rec.ir !== e.ir) bad_value(2, "rec.ir", e.ir, rec.ir);
		if (rec.cls !== e.cls) bad_value(2, "rec.cls", e.cls, rec.cls);
		if (rec.f !== e.f) bad_value(2, "rec.f", e.f, rec.f);
		if (rec.two_word !== e.two_word) bad_value(3, "rec.two_word", e.two_word, rec.two_word);
		if (e.two_word && rec.arg !== e.arg) bad_value(3, "rec.arg", e.arg, rec.arg);
		if (rec.xi !== e.xi) bad_value(4, "rec.xi", e.xi, rec.xi);
		if (rec.nef !== e.nef) bad_value(5, "rec.nef", e.nef, rec.nef);
		if (rec.xi === 1'b1 && rec.nef !== 1'b1) failure(5, "nef clear on an illegal instruction");
		seen[int'(e.cls)] = 1'b1;
		if (e.two_word) n_two++;
		model_pc = model_pc + (e.two_word ? 16'd2 : 16'd1);	// Skip the argument word
		n_rec++;
	endtask

	task automatic finish_run();
		int total;
		total = 0;
		if (seen !== '1) failure(2, "not every opcode class was seen");
		if (n_two == 0) failure(3, "no two-word instruction was seen");
		if (stalls == 0) failure(6, "the sink never held a record back");
		for (int t = 1; t <= 6; t++) begin
			$display("Test %0d %s: %s, %0d errors", t, test_title(t),
				test_err[t] == 0 ? "pass" : "fail", test_err[t]);
			total += test_err[t];
		end
		$display("Records %0d, two-word %0d, stall cycles %0d, errors %0d",
			n_rec, n_two, stalls, total);
		errors <= total;
		done <= 1'b1;
	endtask

	initial begin
		done = 1'b0;
		errors = 0;
		n_rec = 0;
		n_two = 0;
		stalls = 0;
		seen = '0;
		first_seen = 1'b0;
		foreach (test_err[t]) test_err[t] = 0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			in_reset = 1'b1;
			model_pc = RESET_PC;
			bus_busy = 1'b0;
			held = 1'b0;
		end else if (!done) begin
			if (in_reset && (cyc !== 1'b0 || stb !== 1'b0 || rec_valid !== 1'b0)) begin
				failure(1, "bus or record active right after reset");
			end
			in_reset = 1'b0;
			if (stb !== cyc) bad_value(1, "stb", cyc, stb);
			if (we !== 1'b0) bad_value(1, "we", 1'b0, we);
			if (cyc && !first_seen) begin
				first_seen = 1'b1;
				if (adr !== RESET_PC) bad_value(1, "adr", RESET_PC, adr);
			end
			if (bus_busy && adr !== bus_adr) bad_value(1, "adr", bus_adr, adr);	// Stable in cycle
			if (!bus_busy) bus_adr = adr;
			bus_busy = cyc && !ack;
			if (rec_valid && cyc) failure(6, "bus cycle raised while a record is pending");
			if (held && !rec_valid) failure(6, "record withdrawn before transfer");
			if (held && rec_valid && rec !== held_rec) bad_value(6, "rec", held_rec, rec);
			held = rec_valid && !rec_ready;
			held_rec = rec;
			if (held) stalls++;
			if (rec_valid && rec_ready) begin
				check_record();
				if (n_rec == n_records) finish_run();
			end
		end
	end

endmodule

// ==== bench/pd_tb.sv ====
// Testbench top for the fetch and decode front end
//   clock, reset and seeded memory fill with biased opcodes
//   Wishbone memory model with random ack delay
//   random rec_ready, q and r0 on falling edges
//   cycle-count timeout and the final verdict

`timescale 1ns/1ns

`define INOU_USER_ILLEGAL 1'b1	// 1'b0 for the second run

module pd_tb;

	import pd_pkg::*;

	localparam int N_RECORDS = 120;
	localparam int TIMEOUT_CYCLES = N_RECORDS * (2 * 5 + 8) + 20;
	localparam bit INOU_ILL = `INOU_USER_ILLEGAL;
	localparam int SEED = 32149;

	logic clk = 1'b0;
	logic rst_n;
	logic cyc, stb, we, ack;
	word_t adr, dat_r;
	logic q, rec_valid, rec_ready, done;
	r0_t r0;
	pd_rec_t rec;
	int errors, cycles, wait_cnt;
	logic busy;			// Bus request seen and not yet acked
	word_t mem [0:255];	// Program memory shared with the checker

	pd_top #(.inou_user_illegal(INOU_ILL)) dut (
		.clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_r(dat_r), .ack(ack), .q(q), .r0(r0), .rec(rec),
		.rec_valid(rec_valid), .rec_ready(rec_ready)
	);

	pd_check #(.inou_user_illegal(INOU_ILL), .n_records(N_RECORDS)) chk (
		.clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .ack(ack),
		.q(q), .r0(r0), .rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready),
		.done(done), .errors(errors)
	);

	always #50 clk = ~clk;	// 100 ns period

	// Random word with an evenly picked class and C=0 in a third of the normal args
	function automatic word_t make_insn();
		int k;
		word_t w;
		k = $urandom % 12;
		w = word_t'($urandom);
		case (k)
			0: w[0:5] = 6'($urandom % 16);
			1: w[0:5] = ($urandom % 4 == 0) ? (($urandom % 2) ? OP_OU : OP_IN)
				: 6'(6'o20 + $urandom % 16);	// IN/OU favoured
			2: w[0:5] = 6'(6'o40 + $urandom % 16);
			3: w[0:5] = 6'(6'o60 + $urandom % 8);
			default: w[0:5] = 6'(6'o70 + k - 4);	// One group opcode each
		endcase
		if (k == 1 || k == 2) begin
			w[13:15] = ($urandom % 3 == 0) ? 3'b000 : 3'(1 + $urandom % 7);
		end
		return w;
	endfunction

	// Memory answers after 0 to 3 extra cycles
	always @(negedge clk) begin
		if (ack) begin
			ack = 1'b0;		// Single-cycle ack
		end else if (rst_n && cyc) begin
			if (!busy) begin
				busy = 1'b1;
				wait_cnt = $urandom % 4;
			end
			if (wait_cnt == 0) begin
				ack = 1'b1;
				dat_r = mem[adr[8:15]];
				busy = 1'b0;
			end else begin
				wait_cnt--;
			end
		end
	end

	// Sink and status stimulus
	always @(negedge clk) begin
		rec_ready = ($urandom % 8) < 5;
		if (!rec_valid) begin
			q = 1'($urandom % 2);	// Only between records
			r0 = r0_t'($urandom);
		end
	end

	initial begin
		rst_n = 1'b0;
		dat_r = '0;
		ack = 1'b0;
		q = 1'b0;
		r0 = '0;
		rec_ready = 1'b0;
		busy = 1'b0;
		wait_cnt = 0;
		cycles = 0;
		void'($urandom(SEED));
		for (int i = 0; i < 256; i++) begin
			mem[i] = make_insn();
		end
		repeat (5) @(posedge clk);
		@(negedge clk) rst_n = 1'b1;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!done || errors != 0) begin
			if (!done) begin
				$display("Run stopped: no end of test after %0d cycles", cycles);
			end
			$display("Done: errors found");
		end else begin
			$display("Done: no errors");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/pd_pkg.sv
logic/ifetch.sv
logic/op_decode.sv
logic/op_check.sv
logic/pd_top.sv
bench/pd_check.sv
bench/pd_tb.sv
